// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_top
LINT_TOP  ?= id_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
id_pkg.sv
id_fifo.sv
id_stage_ctrl.sv
id_decoder.sv
id_imm_gen.sv
id_top.sv
tb_clkgen.sv
tb_id_top.sv

// File: id_decoder.sv
`default_nettype none

module id_decoder import id_pkg::*; (
    input  wire inst_t inst,
    output op_class_t  op_class,
    output imm_fmt_t   imm_fmt,
    output logic       uses_rs2,
    output funct3_t    funct3,
    output reg_addr_t  rd,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2
);

    opcode_t opc;

    assign opc    = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];                 // raw fields, class decides use
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // major opcode to class, with the reserved funct3 holes
    always_comb begin
        case (opc)
            OPC_LUI:    op_class = OP_LUI;
            OPC_AUIPC:  op_class = OP_AUIPC;
            OPC_JAL:    op_class = OP_JAL;
            OPC_JALR:   op_class = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
            OPC_BRANCH: begin
                if (funct3 == 3'b010 || funct3 == 3'b011)
                    op_class = OP_ILLEGAL;      // no branch on these
                else
                    op_class = OP_BRANCH;
            end
            OPC_LOAD:   op_class = (funct3 == 3'b111) ? OP_ILLEGAL : OP_LOAD;
            OPC_STORE:  op_class = (funct3 > 3'b011) ? OP_ILLEGAL : OP_STORE; // sb..sd
            OPC_IMM:    op_class = OP_IMM;
            OPC_IMM_32: op_class = OP_IMM_32;
            OPC_REG:    op_class = OP_REG;      // m ext lands here too
            OPC_REG_32: op_class = OP_REG_32;
            OPC_SYSTEM: op_class = OP_SYSTEM;   // csr and trap insts
            default:    op_class = OP_ILLEGAL;
        endcase
    end

    // immediate layout per class
    always_comb begin
        case (op_class)
            OP_JALR,
            OP_LOAD,
            OP_IMM,
            OP_IMM_32,
            OP_SYSTEM:  imm_fmt = IMM_I;        // csr addr rides in imm
            OP_STORE:   imm_fmt = IMM_S;
            OP_BRANCH:  imm_fmt = IMM_B;
            OP_LUI,
            OP_AUIPC:   imm_fmt = IMM_U;
            OP_JAL:     imm_fmt = IMM_J;
            default:    imm_fmt = IMM_NONE;     // reg ops and illegal
        endcase
    end

    // rs2 is a real source only for these
    always_comb begin
        case (op_class)
            OP_BRANCH,
            OP_STORE,
            OP_REG,
            OP_REG_32: uses_rs2 = 1'b1;
            default:   uses_rs2 = 1'b0;        // rs2 bits are imm or unused
        endcase
    end

endmodule

`default_nettype wire

// File: id_fifo.sv
`default_nettype none

module id_fifo import id_pkg::*; #(
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_SLACK = 4
) (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  flush,                   // drops all entries
    input  wire logic  push,
    input  wire xlen_t push_pc,
    input  wire inst_t push_inst,
    input  wire logic  pop,
    output xlen_t      head_pc,
    output inst_t      head_inst,
    output logic       empty,
    output logic       almost_full              // count at or above depth - slack
);

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
    localparam int ENTRY_W = XLEN + $bits(inst_t);

    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] AF_LEVEL   = CNT_W'(FIFO_DEPTH - FIFO_SLACK);
    localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(FIFO_DEPTH);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];       // {pc, inst} per slot
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                       // same-edge push is lost too
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or push+pop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) mem[wr_ptr] <= {push_pc, push_inst};
    end

    assign {head_pc, head_inst} = mem[rd_ptr];  // valid while !empty
    assign empty       = (count == '0);
    assign almost_full = (count >= AF_LEVEL);   // upstream sees in_ready low

    // in_ready slack must keep the writer off a full buffer
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count < FULL_LEVEL);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// File: id_imm_gen.sv
`default_nettype none

module id_imm_gen import id_pkg::*; (
    input  wire inst_t    inst,
    input  wire imm_fmt_t imm_fmt,
    output xlen_t         imm
);

    logic sign;

    assign sign = inst[31];                     // every format signs from bit 31

    always_comb begin
        case (imm_fmt)
            IMM_I: imm = {{(XLEN-12){sign}}, inst[31:20]};
            IMM_S: imm = {{(XLEN-12){sign}}, inst[31:25], inst[11:7]};
            IMM_B: imm = {{(XLEN-13){sign}},
                          inst[31],
                          inst[7],              // imm[11]
                          inst[30:25],
                          inst[11:8],
                          1'b0};                // halfword aligned
            IMM_U: imm = {{(XLEN-32){sign}}, inst[31:12], 12'b0};
            IMM_J: imm = {{(XLEN-21){sign}},
                          inst[31],
                          inst[19:12],
                          inst[20],             // imm[11]
                          inst[30:21],
                          1'b0};
            default: imm = '0;                  // no immediate
        endcase
    end

endmodule

`default_nettype wire

// File: id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int XLEN = 64;                   // rv64 data width

    typedef logic [XLEN-1:0] xlen_t;            // pc and immediates
    typedef logic [31:0]     inst_t;            // raw instruction word
    typedef logic [4:0]      reg_addr_t;        // x0 .. x31
    typedef logic [2:0]      funct3_t;          // minor opcode field
    typedef logic [6:0]      opcode_t;          // major opcode in inst[6:0]

    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_IMM,                                 // addi, slti, shifts ...
        OP_IMM_32,                              // addiw family
        OP_REG,                                 // includes mul/div
        OP_REG_32,                              // includes mulw/divw
        OP_SYSTEM,                              // csr, ecall, ebreak, mret
        OP_ILLEGAL
    } op_class_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_t;

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_IMM    = 7'b0010011;
    localparam opcode_t OPC_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_REG    = 7'b0110011;
    localparam opcode_t OPC_REG_32 = 7'b0111011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

// File: id_stage_ctrl.sv
`default_nettype none

module id_stage_ctrl import id_pkg::*; (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  flush,                   // branch redirect from ex
    input  wire logic  in_valid,
    input  wire xlen_t in_pc,
    input  wire inst_t in_inst,
    input  wire logic  out_ready,
    input  wire xlen_t head_pc,
    input  wire inst_t head_inst,
    input  wire logic  empty,
    input  wire logic  almost_full,
    input  wire logic  ex_valid,
    input  wire inst_t ex_inst,                 // instruction sitting in ex
    input  wire logic  uses_rs2,                // held inst reads rs2
    output logic       in_ready,
    output logic       push,
    output xlen_t      push_pc,
    output inst_t      push_inst,
    output logic       pop,
    output logic       out_valid,
    output xlen_t      out_pc,
    output inst_t      out_inst
);

    logic      reg_valid;                       // stage register occupied
    xlen_t     reg_pc;
    inst_t     reg_inst;
    logic      in_fire;
    logic      advance;
    logic      bypass;
    logic      stall;
    opcode_t   ex_opc;
    reg_addr_t ex_rd;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;

    assign in_ready = !almost_full;
    assign in_fire  = in_valid && in_ready;

    // load-use interlock against the load in ex
    assign ex_opc = ex_inst[6:0];
    assign ex_rd  = ex_inst[11:7];
    assign id_rs1 = reg_inst[19:15];
    assign id_rs2 = reg_inst[24:20];
    assign stall  = reg_valid && ex_valid && (ex_opc == OPC_LOAD) && (ex_rd != '0)
                    && ((ex_rd == id_rs1) || ((ex_rd == id_rs2) && uses_rs2));

    assign advance = !reg_valid || (out_ready && !stall); // slot frees this edge
    assign bypass  = advance && empty && in_fire;         // fifo skipped
    assign pop     = advance && !empty && !flush;
    assign push    = in_fire && !bypass && !flush;        // keeps order behind head
    assign push_pc   = in_pc;
    assign push_inst = in_inst;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_valid <= 1'b0;
        end else if (flush) begin
            reg_valid <= 1'b0;                  // drop held inst
        end else if (advance) begin
            reg_valid <= !empty || in_fire;     // head or bypassed input
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !flush) begin
            reg_pc   <= empty ? in_pc : head_pc;
            reg_inst <= empty ? in_inst : head_inst;
        end
    end

    assign out_valid = reg_valid && !stall;     // drops with stall, same cycle
    assign out_pc    = reg_pc;
    assign out_inst  = reg_inst;

    // ex must see a steady payload until it takes it
    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_pc) && $stable(out_inst));

endmodule

`default_nettype wire

// File: id_top.sv
`default_nettype none

module id_top import id_pkg::*; #(
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_SLACK = 4                // free slots left when in_ready drops
) (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  in_valid,                // from fetch
    input  wire xlen_t in_pc,
    input  wire inst_t in_inst,
    output logic       in_ready,
    output logic       out_valid,               // to execute
    output xlen_t      out_pc,
    output inst_t      out_inst,
    output op_class_t  out_class,
    output funct3_t    out_funct3,
    output reg_addr_t  out_rd,
    output reg_addr_t  out_rs1,
    output reg_addr_t  out_rs2,
    output xlen_t      out_imm,
    input  wire logic  out_ready,
    input  wire logic  ex_valid,                // ex feedback for interlock
    input  wire inst_t ex_inst,
    input  wire logic  flush
);

    logic     push;
    xlen_t    push_pc;
    inst_t    push_inst;
    logic     pop;
    xlen_t    head_pc;
    inst_t    head_inst;
    logic     fifo_empty;
    logic     almost_full;
    logic     uses_rs2;
    imm_fmt_t imm_fmt;

    id_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_SLACK(FIFO_SLACK)) fifo_i (
        .clk, .arst_n, .flush, .push, .push_pc, .push_inst, .pop,
        .head_pc, .head_inst, .empty(fifo_empty), .almost_full
    );

    id_stage_ctrl ctrl_i (
        .clk, .arst_n, .flush, .in_valid, .in_pc, .in_inst, .out_ready,
        .head_pc, .head_inst, .empty(fifo_empty), .almost_full,
        .ex_valid, .ex_inst, .uses_rs2,
        .in_ready, .push, .push_pc, .push_inst, .pop,
        .out_valid, .out_pc, .out_inst
    );

    id_decoder dec_i (
        .inst(out_inst), .op_class(out_class), .imm_fmt, .uses_rs2,
        .funct3(out_funct3), .rd(out_rd), .rs1(out_rs1), .rs2(out_rs2)
    );

    id_imm_gen imm_i (.inst(out_inst), .imm_fmt, .imm(out_imm)); // held inst only

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;                          // release away from the rising edge
    end
endmodule

`default_nettype wire

// File: tb_id_top.sv
`default_nettype none

module tb_id_top import id_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_SLACK = 4;
    localparam int NROWS      = 18;
    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        inst_t     inst;
        xlen_t     pc;
        op_class_t cls;
        xlen_t     imm;                         // hand-encoded from the isa formats
        logic      ex_v;
        inst_t     ex_inst;                     // what sits in execute meanwhile
        logic      stall;
    } row_t;

    logic        clk, arst_n, in_valid, in_ready, out_valid, out_ready, ex_valid, flush;
    xlen_t       in_pc, out_pc, out_imm;
    inst_t       in_inst, out_inst, ex_inst;
    op_class_t   out_class;
    funct3_t     out_funct3;
    reg_addr_t   out_rd, out_rs1, out_rs2;
    row_t        rows [NROWS];
    int          nrows_set  = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    logic [31:0] rnd_state  = 32'd89;
    xlen_t       pc_q [$];                      // scoreboard, accepted pairs in order
    inst_t       inst_q [$];

    tb_clkgen #(.PERIOD(CLK_PERIOD)) clk_i (.clk, .arst_n);
    id_top #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_SLACK(FIFO_SLACK)) dut_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic report_mismatch(input string name, input string got, input string exp);
        value_errs++;
        $display("[FAIL] %0t ns %s got %s expected %s", $time, name, got, exp);
    endtask
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask
    task automatic check_class(input string name, input op_class_t got, input op_class_t exp);
        if (got !== exp) report_mismatch(name, got.name(), exp.name());
    endtask
    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask
    task automatic check_f3(input string name, input funct3_t got, input funct3_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic add_row(input inst_t i, input op_class_t c, input xlen_t imm,
                           input logic ex_v, input inst_t ex_i, input logic stall);
        rows[nrows_set] = '{i, 64'h8000_0000 + 64'(4 * nrows_set), c, imm, ex_v, ex_i, stall};
        nrows_set++;
    endtask

    task automatic drive_pair(input logic valid);
        rnd_state = xorshift(rnd_state);
        in_pc     = {32'h0, rnd_state[31:2], 2'b00};
        in_inst   = xorshift(rnd_state);
        in_valid  = valid;
    endtask

    // one row alone through an empty stage, ex held for two cycles
    task automatic apply_row(input row_t r);
        while (!in_ready) @(negedge clk);
        in_valid = 1'b1;
        in_pc    = r.pc;
        in_inst  = r.inst;
        ex_valid = r.ex_v;
        ex_inst  = r.ex_inst;
        @(negedge clk);                         // bypassed into the stage register
        in_valid  = 1'b0;
        out_ready = r.stall;                    // stalled inst must stay put
        repeat (2) begin
            check_bit("out_valid", out_valid, !r.stall);
            @(negedge clk);
        end
        ex_valid  = 1'b0;                       // load moves on
        out_ready = 1'b0;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b1);
        check_class("out_class", out_class, r.cls);
        check_f3("out_funct3", out_funct3, r.inst[14:12]);
        check_reg("out_rd", out_rd, r.inst[11:7]);
        check_reg("out_rs1", out_rs1, r.inst[19:15]);
        check_reg("out_rs2", out_rs2, r.inst[24:20]);
        check_xlen("out_imm", out_imm, r.imm);
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic drain_stage();
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while (pc_q.size() != 0) @(negedge clk);
        out_ready = 1'b0;
        check_bit("out_valid", out_valid, 1'b0); // nothing left behind
    endtask

    // scoreboard: output side first, then flush, then input side
    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            if (pc_q.size() == 0) begin
                other_errs++;
                $display("%0t ns: execute took an instruction that was never accepted", $time);
            end else begin
                check_xlen("out_pc", out_pc, pc_q.pop_front());
                check_inst("out_inst", out_inst, inst_q.pop_front());
            end
        end
        if (flush) begin
            pc_q.delete();
            inst_q.delete();                    // same-edge input dropped as well
        end else if (arst_n && in_valid && in_ready) begin
            pc_q.push_back(in_pc);
            inst_q.push_back(in_inst);
        end
    end

    initial begin
        #(NROWS * 40 * CLK_PERIOD);
        $display("timeout: the run did not finish within its cycle budget");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        out_ready = 1'b0;
        ex_valid  = 1'b0;
        ex_inst   = '0;
        flush     = 1'b0;
        add_row(32'hFFFFF2B7, OP_LUI,     64'hFFFF_FFFF_FFFF_F000, 1'b0, 32'h0, 1'b0);
        add_row(32'h12345097, OP_AUIPC,   64'h0000_0000_1234_5000, 1'b0, 32'h0, 1'b0);
        add_row(32'hFFDFF0EF, OP_JAL,     64'hFFFF_FFFF_FFFF_FFFC, 1'b0, 32'h0, 1'b0);
        add_row(32'h00808067, OP_JALR,    64'd8, 1'b0, 32'h0, 1'b0);
        add_row(32'h00809067, OP_ILLEGAL, 64'd0, 1'b0, 32'h0, 1'b0);          // jalr f3 001
        add_row(32'hFE208CE3, OP_BRANCH,  64'hFFFF_FFFF_FFFF_FFF8, 1'b1, 32'h0004B103, 1'b1);
        add_row(32'hFE20ACE3, OP_ILLEGAL, 64'd0, 1'b0, 32'h0, 1'b0);          // branch f3 010
        add_row(32'hFF013183, OP_LOAD,    64'hFFFF_FFFF_FFFF_FFF0, 1'b0, 32'h0, 1'b0);
        add_row(32'hFF017183, OP_ILLEGAL, 64'd0, 1'b0, 32'h0, 1'b0);          // load f3 111
        add_row(32'hFE513423, OP_STORE,   64'hFFFF_FFFF_FFFF_FFE8, 1'b0, 32'h0, 1'b0);
        add_row(32'hFE514423, OP_ILLEGAL, 64'd0, 1'b0, 32'h0, 1'b0);          // store f3 100
        add_row(32'hFFF58513, OP_IMM,     64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 32'h0004B583, 1'b1);
        add_row(32'h0053039B, OP_IMM_32,  64'd5, 1'b1, 32'h0004B283, 1'b0);  // rs2 bits unused
        add_row(32'h003100B3, OP_REG,     64'd0, 1'b1, 32'h0004B183, 1'b1);  // rs2 hit
        add_row(32'h0262823B, OP_REG_32,  64'd0, 1'b0, 32'h0, 1'b0);          // mulw
        add_row(32'h300020F3, OP_SYSTEM,  64'h300, 1'b0, 32'h0, 1'b0);        // csrrs mstatus
        add_row(32'h00000073, OP_SYSTEM,  64'd0, 1'b1, 32'h0004B003, 1'b0);  // ld x0 in ex
        add_row(32'hFFFFFFFF, OP_ILLEGAL, 64'd0, 1'b0, 32'h0, 1'b0);          // opcode 7f
        wait (arst_n);
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        foreach (rows[i]) apply_row(rows[i]);
        for (int n = 0; n < FIFO_DEPTH - FIFO_SLACK + 1; n++) begin
            check_bit("in_ready", in_ready, 1'b1);
            drive_pair(1'b1);                   // out_ready low, stage and fifo fill
            @(negedge clk);
        end
        check_bit("in_ready", in_ready, 1'b0);
        for (int n = 0; n < 80; n++) begin
            rnd_state = xorshift(rnd_state);
            out_ready = rnd_state[7] | rnd_state[3];
            drive_pair(rnd_state[5]);
            @(negedge clk);
        end
        drain_stage();
        for (int n = 0; n < 3; n++) begin
            drive_pair(1'b1);
            @(negedge clk);
        end
        drive_pair(1'b1);
        flush = 1'b1;
        @(negedge clk);
        flush    = 1'b0;
        in_valid = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        for (int n = 0; n < 2; n++) begin
            drive_pair(1'b1);
            @(negedge clk);
        end
        drain_stage();
        $display("error counts: mismatches %0d, other %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end
endmodule

`default_nettype wire
